//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module renameTb -f renameTop.f

sim:
	verilator --binary --timing --assert --top-module renameTb -Mdir obj_dir -f renameTop.f
	./obj_dir/VrenameTb | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- include/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Ops renamed per cycle
`define RENAME_WIDTH 2
`define RENAME_WB_PORTS 2

// Architectural registers map onto physical tags
`define RENAME_NUM_REGS 16
`define RENAME_NUM_TAGS 32

`endif

//--- renameTop.f
+incdir+include
rtl/isaPkg.sv
rtl/renamePkg.sv
rtl/ratIf.sv
rtl/renameTable.sv
rtl/tagBuffer.sv
rtl/renameStage.sv
rtl/renameTop.sv
verification/rename_properties.sv
verification/renameTb.sv

//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_LSU = 2'd1,
        FU_BRANCH = 2'd2
    } fuType_t;

    // Loads and stores sit at the top of the encoding
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SLT = 4'd7,
        OP_LB = 4'd8,
        OP_LW = 4'd9,
        OP_SB = 4'd10,
        OP_SW = 4'd11
    } opcode_t;

    function automatic logic isStore(opcode_t op);
        return (op == OP_SB) || (op == OP_SW);
    endfunction

endpackage

`default_nettype wire

//--- rtl/ratIf.sv
`default_nettype none
`include "rename_config.svh"

interface ratIf;
    import renamePkg::*;

    // Two source lookups per lane, rs0 at even index
    regId_t lookupId [2*`RENAME_WIDTH];
    tag_t lookupTag [2*`RENAME_WIDTH];
    logic lookupAvail [2*`RENAME_WIDTH];

    logic issueValid [`RENAME_WIDTH];
    regId_t issueId [`RENAME_WIDTH];
    tag_t issueTag [`RENAME_WIDTH];

    // prevTag is the committed mapping before this cycle's commits
    logic commitValid [`RENAME_WIDTH];
    regId_t commitId [`RENAME_WIDTH];
    tag_t commitTag [`RENAME_WIDTH];
    tag_t prevTag [`RENAME_WIDTH];

    logic wbValid [`RENAME_WB_PORTS];
    tag_t wbTag [`RENAME_WB_PORTS];
    logic flush;

    modport stage (
        output lookupId, issueValid, issueId, issueTag,
        output commitValid, commitId, commitTag, wbValid, wbTag, flush,
        input lookupTag, lookupAvail, prevTag
    );

    modport tbl (
        input lookupId, issueValid, issueId, issueTag,
        input commitValid, commitId, commitTag, wbValid, wbTag, flush,
        output lookupTag, lookupAvail, prevTag
    );

endinterface

`default_nettype wire

//--- rtl/renamePkg.sv
`default_nettype none
`include "rename_config.svh"

package renamePkg;

    typedef logic [$clog2(`RENAME_NUM_TAGS)-1:0] tag_t;
    typedef logic [$clog2(`RENAME_NUM_REGS)-1:0] regId_t;

    // Wraps around, compare with modular distance
    typedef logic [5:0] sqN_t;

    typedef struct packed {
        logic valid;
        regId_t rs0;
        regId_t rs1;
        regId_t rd;
        isaPkg::fuType_t fu;
        isaPkg::opcode_t opcode;
    } decUOp_t;

    typedef struct packed {
        regId_t rd;
        isaPkg::fuType_t fu;
        isaPkg::opcode_t opcode;
        tag_t tagA;
        tag_t tagB;
        logic availA;
        logic availB;
        tag_t tagDst;
        sqN_t sqN;
        sqN_t loadSqN;
        sqN_t storeSqN;
    } renUOp_t;

    // Retiring op as reported by the ROB
    typedef struct packed {
        logic valid;
        regId_t nmDst;
        tag_t tagDst;
    } comUOp_t;

endpackage

`default_nettype wire

//--- rtl/renameStage.sv
`default_nettype none
`include "rename_config.svh"

module renameStage (
    input wire clk,
    input wire rst,
    input wire en,
    input wire frontEn,
    input wire renamePkg::decUOp_t inUop [`RENAME_WIDTH],
    input wire renamePkg::comUOp_t comUop [`RENAME_WIDTH],
    input wire wbValid [`RENAME_WB_PORTS],
    input wire renamePkg::tag_t wbTag [`RENAME_WB_PORTS],
    input wire flush,
    input wire renamePkg::sqN_t flushSqN,
    input wire renamePkg::sqN_t flushLoadSqN,
    input wire renamePkg::sqN_t flushStoreSqN,
    output logic outValid [`RENAME_WIDTH],
    output renamePkg::renUOp_t outUop [`RENAME_WIDTH],
    output renamePkg::sqN_t nextSqN,
    output logic stall
);
    import renamePkg::*;
    import isaPkg::*;

    localparam int W = `RENAME_WIDTH;
    localparam int P = `RENAME_WB_PORTS;

    ratIf rat ();

    logic enough;
    logic doRename;
    logic allocReq [W];
    tag_t allocTag [W];
    logic comAct [W];
    logic newest [W];
    logic freeValid [W];
    tag_t freeTag [W];
    tag_t commitTag [W];
    sqN_t seqCnt;
    sqN_t loadCnt;
    sqN_t storeCnt;
    sqN_t seqNxt;
    sqN_t loadNxt;
    sqN_t storeNxt;
    sqN_t laneSqN [W];
    sqN_t laneLoadSqN [W];
    sqN_t laneStoreSqN [W];

    assign stall = !enough;
    assign doRename = en && frontEn && enough && !flush;
    assign nextSqN = seqCnt;

    // Load and store numbers point at the next op of that kind
    always_comb begin
        seqNxt = seqCnt;
        loadNxt = loadCnt;
        storeNxt = storeCnt;
        for (int i = 0; i < W; i++) begin
            laneSqN[i] = seqNxt;
            laneLoadSqN[i] = loadNxt;
            laneStoreSqN[i] = storeNxt;
            if (inUop[i].valid) begin
                seqNxt = seqNxt + sqN_t'(1);
                if (inUop[i].fu == FU_LSU) begin
                    if (isStore(inUop[i].opcode))
                        storeNxt = storeNxt + sqN_t'(1);
                    else
                        loadNxt = loadNxt + sqN_t'(1);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < W; i++) begin
            rat.lookupId[2 * i] = inUop[i].rs0;
            rat.lookupId[2 * i + 1] = inUop[i].rs1;
            allocReq[i] = doRename && inUop[i].valid && inUop[i].rd != '0;
        end
    end

    always_comb begin
        for (int i = 0; i < W; i++) begin
            rat.issueValid[i] = allocReq[i];
            rat.issueId[i] = inUop[i].rd;
            rat.issueTag[i] = allocTag[i];
        end
    end

    always_comb begin
        for (int i = 0; i < W; i++) begin
            comAct[i] = comUop[i].valid && comUop[i].nmDst != '0;
            commitTag[i] = comUop[i].tagDst;
            rat.commitValid[i] = comAct[i];
            rat.commitId[i] = comUop[i].nmDst;
            rat.commitTag[i] = commitTag[i];
        end
    end

    // Only the newest commit to a register frees the old mapping
    // Older commits to it free their own tag, which is overwritten at once
    always_comb begin
        for (int i = 0; i < W; i++) begin
            newest[i] = 1'b1;
            for (int j = i + 1; j < W; j++) begin
                if (comAct[j] && comUop[j].nmDst == comUop[i].nmDst)
                    newest[i] = 1'b0;
            end
            freeValid[i] = comAct[i];
            freeTag[i] = newest[i] ? rat.prevTag[i] : commitTag[i];
        end
    end

    assign rat.wbValid = wbValid;
    assign rat.wbTag = wbTag;
    assign rat.flush = flush;

    renameTable ratTable (
        .clk(clk),
        .rst(rst),
        .rat(rat.tbl)
    );

    tagBuffer freeTags (
        .clk(clk),
        .rst(rst),
        .allocReq(allocReq),
        .freeValid(freeValid),
        .freeTag(freeTag),
        .commitTag(commitTag),
        .flush(flush),
        .allocTag(allocTag),
        .enough(enough)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            seqCnt <= '0;
            loadCnt <= '0;
            storeCnt <= '0;
            outValid <= '{default: 1'b0};
        end else if (flush) begin
            seqCnt <= flushSqN;
            loadCnt <= flushLoadSqN;
            storeCnt <= flushStoreSqN;
            outValid <= '{default: 1'b0};
        end else if (!en || !enough) begin
            outValid <= '{default: 1'b0};
        end else if (frontEn) begin
            seqCnt <= seqNxt;
            loadCnt <= loadNxt;
            storeCnt <= storeNxt;
            for (int i = 0; i < W; i++)
                outValid[i] <= inUop[i].valid;
        end
    end

    always_ff @(posedge clk) begin
        if (doRename) begin
            for (int i = 0; i < W; i++) begin
                outUop[i].rd <= inUop[i].rd;
                outUop[i].fu <= inUop[i].fu;
                outUop[i].opcode <= inUop[i].opcode;
                outUop[i].tagA <= rat.lookupTag[2 * i];
                outUop[i].tagB <= rat.lookupTag[2 * i + 1];
                outUop[i].availA <= rat.lookupAvail[2 * i];
                outUop[i].availB <= rat.lookupAvail[2 * i + 1];
                outUop[i].tagDst <= (inUop[i].rd != '0) ? allocTag[i] : '0;
                outUop[i].sqN <= laneSqN[i];
                outUop[i].loadSqN <= laneLoadSqN[i];
                outUop[i].storeSqN <= laneStoreSqN[i];
            end
        end else if (en && !frontEn) begin
            // Held ops are read later, so keep their operand state current
            for (int p = 0; p < P; p++) begin
                for (int i = 0; i < W; i++) begin
                    if (wbValid[p] && outUop[i].tagA == wbTag[p])
                        outUop[i].availA <= 1'b1;
                    if (wbValid[p] && outUop[i].tagB == wbTag[p])
                        outUop[i].availB <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/renameTable.sv
`default_nettype none
`include "rename_config.svh"

module renameTable (
    input wire clk,
    input wire rst,
    ratIf.tbl rat
);
    import renamePkg::*;

    localparam int W = `RENAME_WIDTH;
    localparam int P = `RENAME_WB_PORTS;
    localparam int NR = `RENAME_NUM_REGS;
    localparam int NT = `RENAME_NUM_TAGS;

    tag_t specMap [NR];
    tag_t comMap [NR];
    tag_t comMapNxt [NR];
    logic [NT-1:0] ready;

    regId_t lkId;
    tag_t lkTag;
    logic lkAvail;

    always_comb begin
        for (int k = 0; k < 2 * W; k++) begin
            lkId = rat.lookupId[k];
            lkTag = specMap[lkId];
            lkAvail = ready[lkTag];
            // Results arriving this cycle
            for (int p = 0; p < P; p++) begin
                if (rat.wbValid[p] && rat.wbTag[p] == lkTag)
                    lkAvail = 1'b1;
            end
            // Earlier lane in the group writes this register, last one wins
            for (int j = 0; j < k / 2; j++) begin
                if (rat.issueValid[j] && rat.issueId[j] == lkId) begin
                    lkTag = rat.issueTag[j];
                    lkAvail = 1'b0;
                end
            end
            if (lkId == '0) begin
                lkTag = '0;
                lkAvail = 1'b1;
            end
            rat.lookupTag[k] = lkTag;
            rat.lookupAvail[k] = lkAvail;
        end
    end

    always_comb begin
        comMapNxt = comMap;
        for (int i = 0; i < W; i++) begin
            rat.prevTag[i] = comMap[rat.commitId[i]];
            if (rat.commitValid[i])
                comMapNxt[rat.commitId[i]] = rat.commitTag[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NR; r++) begin
                specMap[r] <= tag_t'(r);
                comMap[r] <= tag_t'(r);
            end
            ready <= '1;
        end else begin
            for (int p = 0; p < P; p++) begin
                if (rat.wbValid[p])
                    ready[rat.wbTag[p]] <= 1'b1;
            end
            for (int i = 0; i < W; i++) begin
                if (rat.issueValid[i]) begin
                    specMap[rat.issueId[i]] <= rat.issueTag[i];
                    ready[rat.issueTag[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < W; i++) begin
                if (rat.commitValid[i])
                    ready[rat.commitTag[i]] <= 1'b1;
            end
            comMap <= comMapNxt;
            // Rollback to the architectural state after this cycle's commits
            if (rat.flush)
                specMap <= comMapNxt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/renameTop.sv
`default_nettype none
`include "rename_config.svh"

module renameTop (
    input wire clk,
    input wire rst,
    input wire en,
    input wire frontEn,
    input wire [`RENAME_WIDTH-1:0] inValid,
    input wire renamePkg::regId_t [`RENAME_WIDTH-1:0] inRs0,
    input wire renamePkg::regId_t [`RENAME_WIDTH-1:0] inRs1,
    input wire renamePkg::regId_t [`RENAME_WIDTH-1:0] inRd,
    input wire isaPkg::fuType_t [`RENAME_WIDTH-1:0] inFu,
    input wire isaPkg::opcode_t [`RENAME_WIDTH-1:0] inOpcode,
    input wire [`RENAME_WIDTH-1:0] comValid,
    input wire renamePkg::regId_t [`RENAME_WIDTH-1:0] comNmDst,
    input wire renamePkg::tag_t [`RENAME_WIDTH-1:0] comTagDst,
    input wire [`RENAME_WB_PORTS-1:0] wbValid,
    input wire renamePkg::tag_t [`RENAME_WB_PORTS-1:0] wbTag,
    input wire flush,
    input wire renamePkg::sqN_t flushSqN,
    input wire renamePkg::sqN_t flushLoadSqN,
    input wire renamePkg::sqN_t flushStoreSqN,
    output logic [`RENAME_WIDTH-1:0] outValid,
    output renamePkg::tag_t [`RENAME_WIDTH-1:0] outTagA,
    output renamePkg::tag_t [`RENAME_WIDTH-1:0] outTagB,
    output logic [`RENAME_WIDTH-1:0] outAvailA,
    output logic [`RENAME_WIDTH-1:0] outAvailB,
    output renamePkg::tag_t [`RENAME_WIDTH-1:0] outTagDst,
    output renamePkg::sqN_t [`RENAME_WIDTH-1:0] outSqN,
    output renamePkg::sqN_t [`RENAME_WIDTH-1:0] outLoadSqN,
    output renamePkg::sqN_t [`RENAME_WIDTH-1:0] outStoreSqN,
    output renamePkg::sqN_t nextSqN,
    output logic stall
);
    import renamePkg::*;

    localparam int W = `RENAME_WIDTH;
    localparam int P = `RENAME_WB_PORTS;

    decUOp_t inUop [W];
    comUOp_t comUop [W];
    logic wbValidPort [P];
    tag_t wbTagPort [P];
    logic outValidLane [W];
    renUOp_t outUop [W];

    always_comb begin
        for (int i = 0; i < W; i++) begin
            inUop[i].valid = inValid[i];
            inUop[i].rs0 = inRs0[i];
            inUop[i].rs1 = inRs1[i];
            inUop[i].rd = inRd[i];
            inUop[i].fu = inFu[i];
            inUop[i].opcode = inOpcode[i];
            comUop[i].valid = comValid[i];
            comUop[i].nmDst = comNmDst[i];
            comUop[i].tagDst = comTagDst[i];
        end
        for (int p = 0; p < P; p++) begin
            wbValidPort[p] = wbValid[p];
            wbTagPort[p] = wbTag[p];
        end
    end

    always_comb begin
        for (int i = 0; i < W; i++) begin
            outValid[i] = outValidLane[i];
            outTagA[i] = outUop[i].tagA;
            outTagB[i] = outUop[i].tagB;
            outAvailA[i] = outUop[i].availA;
            outAvailB[i] = outUop[i].availB;
            outTagDst[i] = outUop[i].tagDst;
            outSqN[i] = outUop[i].sqN;
            outLoadSqN[i] = outUop[i].loadSqN;
            outStoreSqN[i] = outUop[i].storeSqN;
        end
    end

    renameStage renamer (
        .clk(clk),
        .rst(rst),
        .en(en),
        .frontEn(frontEn),
        .inUop(inUop),
        .comUop(comUop),
        .wbValid(wbValidPort),
        .wbTag(wbTagPort),
        .flush(flush),
        .flushSqN(flushSqN),
        .flushLoadSqN(flushLoadSqN),
        .flushStoreSqN(flushStoreSqN),
        .outValid(outValidLane),
        .outUop(outUop),
        .nextSqN(nextSqN),
        .stall(stall)
    );

endmodule

`default_nettype wire

//--- rtl/tagBuffer.sv
`default_nettype none
`include "rename_config.svh"

module tagBuffer (
    input wire clk,
    input wire rst,
    input wire allocReq [`RENAME_WIDTH],
    input wire freeValid [`RENAME_WIDTH],
    input wire renamePkg::tag_t freeTag [`RENAME_WIDTH],
    input wire renamePkg::tag_t commitTag [`RENAME_WIDTH],
    input wire flush,
    output renamePkg::tag_t allocTag [`RENAME_WIDTH],
    output logic enough
);
    import renamePkg::*;

    localparam int W = `RENAME_WIDTH;
    localparam int NR = `RENAME_NUM_REGS;
    localparam int NT = `RENAME_NUM_TAGS;

    // A tag is free, speculative (renamed, not yet committed) or neither
    logic [NT-1:0] freeBits;
    logic [NT-1:0] specBits;
    logic [NT-1:0] nxtFree;
    logic [NT-1:0] nxtSpec;
    logic [NT-1:0] searchMask;
    tag_t cand [W];
    logic [W-1:0] candFound;
    int rank;

    // Lowest W free tags, found one after another
    always_comb begin
        searchMask = freeBits;
        for (int k = 0; k < W; k++) begin
            cand[k] = '0;
            candFound[k] = 1'b0;
            for (int t = NT - 1; t >= 0; t--) begin
                if (searchMask[t]) begin
                    cand[k] = tag_t'(t);
                    candFound[k] = 1'b1;
                end
            end
            if (candFound[k])
                searchMask[cand[k]] = 1'b0;
        end
    end

    assign enough = &candFound;

    // Requesting lanes take candidates in lane order
    always_comb begin
        rank = 0;
        for (int i = 0; i < W; i++) begin
            allocTag[i] = cand[rank];
            if (allocReq[i])
                rank = rank + 1;
        end
    end

    always_comb begin
        nxtFree = freeBits;
        nxtSpec = specBits;
        for (int i = 0; i < W; i++) begin
            if (enough && allocReq[i]) begin
                nxtFree[allocTag[i]] = 1'b0;
                nxtSpec[allocTag[i]] = 1'b1;
            end
        end
        for (int i = 0; i < W; i++) begin
            if (freeValid[i])
                nxtSpec[commitTag[i]] = 1'b0;
        end
        for (int i = 0; i < W; i++) begin
            if (freeValid[i]) begin
                nxtFree[freeTag[i]] = 1'b1;
                nxtSpec[freeTag[i]] = 1'b0;
            end
        end
        if (flush) begin
            nxtFree = nxtFree | nxtSpec;
            nxtSpec = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            freeBits <= {{(NT - NR){1'b1}}, {NR{1'b0}}};
            specBits <= '0;
        end else begin
            freeBits <= nxtFree;
            specBits <= nxtSpec;
        end
    end

endmodule

`default_nettype wire

//--- verification/renameTb.sv
`default_nettype none
`include "rename_config.svh"

module renameTb;
    import renamePkg::*;
    import isaPkg::*;

    localparam int W = `RENAME_WIDTH;
    localparam int P = `RENAME_WB_PORTS;
    localparam int NR = `RENAME_NUM_REGS;
    localparam int NT = `RENAME_NUM_TAGS;
    localparam int STEPS = 3000;

    logic clk;
    logic rst;
    logic en;
    logic frontEn;
    logic flush;
    logic [W-1:0] inValid;
    regId_t [W-1:0] inRs0;
    regId_t [W-1:0] inRs1;
    regId_t [W-1:0] inRd;
    fuType_t [W-1:0] inFu;
    opcode_t [W-1:0] inOpcode;
    logic [W-1:0] comValid;
    regId_t [W-1:0] comNmDst;
    tag_t [W-1:0] comTagDst;
    logic [P-1:0] wbValid;
    tag_t [P-1:0] wbTag;
    sqN_t flushSqN;
    sqN_t flushLoadSqN;
    sqN_t flushStoreSqN;
    logic [W-1:0] outValid;
    tag_t [W-1:0] outTagA;
    tag_t [W-1:0] outTagB;
    logic [W-1:0] outAvailA;
    logic [W-1:0] outAvailB;
    tag_t [W-1:0] outTagDst;
    sqN_t [W-1:0] outSqN;
    sqN_t [W-1:0] outLoadSqN;
    sqN_t [W-1:0] outStoreSqN;
    sqN_t nextSqN;
    logic stall;

    // Reference model state
    tag_t specMap [NR];
    tag_t comMap [NR];
    logic [NT-1:0] readySet;
    logic [NT-1:0] freeSet;
    logic [NT-1:0] specSet;
    regId_t robRd [$];
    tag_t robTag [$];
    sqN_t seqCnt;
    sqN_t loadCnt;
    sqN_t storeCnt;
    renUOp_t expUop [W];
    logic [W-1:0] expValid;
    logic renamedLast;
    logic [31:0] rngState;
    int errCount;

    renameTop dut_i (.*);

    bind renameStage renameProperties props_i (
        .clk(clk),
        .rst(rst),
        .allocReq(allocReq),
        .allocTag(allocTag),
        .stall(stall),
        .outValid(outValid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned rnd(int unsigned n);
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState % n;
    endfunction

    function automatic int freeCount();
        int c;
        c = 0;
        for (int t = 0; t < NT; t++)
            c += freeSet[t];
        return c;
    endfunction

    task automatic reportFailure(input string what);
        errCount++;
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            reportFailure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkOutputs();
        checkEq("stall", 32'(stall), 32'(freeCount() < 2));
        checkEq("nextSqN", 32'(nextSqN), 32'(seqCnt));
        for (int i = 0; i < W; i++) begin
            checkEq($sformatf("outValid[%0d]", i), 32'(outValid[i]), 32'(expValid[i]));
            if (expValid[i]) begin
                checkEq($sformatf("outTagA[%0d]", i), 32'(outTagA[i]), 32'(expUop[i].tagA));
                checkEq($sformatf("outTagB[%0d]", i), 32'(outTagB[i]), 32'(expUop[i].tagB));
                checkEq($sformatf("outAvailA[%0d]", i), 32'(outAvailA[i]), 32'(expUop[i].availA));
                checkEq($sformatf("outAvailB[%0d]", i), 32'(outAvailB[i]), 32'(expUop[i].availB));
                checkEq($sformatf("outSqN[%0d]", i), 32'(outSqN[i]), 32'(expUop[i].sqN));
                checkEq($sformatf("outLoadSqN[%0d]", i), 32'(outLoadSqN[i]),
                    32'(expUop[i].loadSqN));
                checkEq($sformatf("outStoreSqN[%0d]", i), 32'(outStoreSqN[i]),
                    32'(expUop[i].storeSqN));
                checkEq($sformatf("outTagDst[%0d]", i), 32'(outTagDst[i]), 32'(expUop[i].tagDst));
            end
        end
        // Newly renamed ops enter the ROB stand-in
        if (renamedLast) begin
            for (int i = 0; i < W; i++) begin
                if (expValid[i] && expUop[i].rd != '0) begin
                    foreach (robTag[k])
                        if (robTag[k] == outTagDst[i])
                            reportFailure("a tag still in flight was handed out again");
                    robRd.push_back(expUop[i].rd);
                    robTag.push_back(outTagDst[i]);
                end
            end
        end
    endtask

    task automatic lookupSrc(input regId_t id, input int lane, input logic [W-1:0] issue,
                             input tag_t newTag [W], output tag_t t, output logic a);
        t = specMap[id];
        a = readySet[t];
        for (int p = 0; p < P; p++)
            if (wbValid[p] && wbTag[p] == t)
                a = 1'b1;
        if (lane == 1 && issue[0] && inRd[0] == id) begin
            t = newTag[0];
            a = 1'b0;
        end
        if (id == '0) begin
            t = '0;
            a = 1'b1;
        end
    endtask

    task automatic driveStep(input int n);
        logic doRename;
        logic newest;
        logic [W-1:0] issue;
        logic [NT-1:0] scan;
        tag_t newTag [W];
        tag_t comOld [NR];
        tag_t freeTag;
        int nCom;
        int idx;

        en = (rnd(8) != 0) || n == 0;
        frontEn = (rnd(4) != 0) || n == 0;
        flush = (rnd(40) == 0) && n != 0;
        flushSqN = sqN_t'(rnd(64));
        flushLoadSqN = sqN_t'(rnd(64));
        flushStoreSqN = sqN_t'(rnd(64));
        for (int i = 0; i < W; i++) begin
            inValid[i] = (rnd(5) != 0) || n == 0;
            inRd[i] = (n == 0) ? regId_t'(i + 3) : regId_t'(rnd(NR));
            inRs0[i] = regId_t'(rnd(NR));
            inRs1[i] = regId_t'(rnd(NR));
            inOpcode[i] = opcode_t'(rnd(12));
            inFu[i] = (inOpcode[i] >= OP_LB) ? FU_LSU : ((rnd(4) == 0) ? FU_BRANCH : FU_ALU);
        end
        // Lane 1 often reads lane 0's destination
        if (rnd(2) == 0)
            inRs0[1] = inRd[0];
        if (n == 0) begin
            inRs0 = '{regId_t'(2), regId_t'(5)};
            inRs1 = '{regId_t'(7), regId_t'(9)};
        end
        // Commits pause in some stretches so the free pool runs dry
        nCom = (n == 0 || n % 300 >= 240) ? 0 : int'(rnd(3));
        if (nCom > robRd.size())
            nCom = robRd.size();
        for (int i = 0; i < W; i++) begin
            comValid[i] = i < nCom;
            comNmDst[i] = (i < nCom) ? robRd[i] : '0;
            comTagDst[i] = (i < nCom) ? robTag[i] : '0;
        end
        for (int p = 0; p < P; p++) begin
            wbValid[p] = robTag.size() > 0 && rnd(2) == 0;
            idx = (robTag.size() > 0) ? int'(rnd(robTag.size())) : 0;
            wbTag[p] = wbValid[p] ? robTag[idx] : '0;
        end

        doRename = en && frontEn && !flush && freeCount() >= 2;
        scan = freeSet;
        for (int i = 0; i < W; i++) begin
            issue[i] = doRename && inValid[i] && inRd[i] != '0;
            newTag[i] = '0;
            if (issue[i]) begin
                for (int t = NT - 1; t >= 0; t--)
                    if (scan[t])
                        newTag[i] = tag_t'(t);
                scan[newTag[i]] = 1'b0;
            end
        end

        if (doRename) begin
            for (int i = 0; i < W; i++) begin
                expValid[i] = inValid[i];
                expUop[i].rd = inRd[i];
                lookupSrc(inRs0[i], i, issue, newTag, expUop[i].tagA, expUop[i].availA);
                lookupSrc(inRs1[i], i, issue, newTag, expUop[i].tagB, expUop[i].availB);
                expUop[i].tagDst = (inRd[i] != '0) ? newTag[i] : '0;
                expUop[i].sqN = seqCnt;
                expUop[i].loadSqN = loadCnt;
                expUop[i].storeSqN = storeCnt;
                if (inValid[i]) begin
                    seqCnt++;
                    if (inFu[i] == FU_LSU && (inOpcode[i] == OP_SB || inOpcode[i] == OP_SW))
                        storeCnt++;
                    else if (inFu[i] == FU_LSU)
                        loadCnt++;
                end
            end
        end else begin
            if (flush || !en || freeCount() < 2)
                expValid = '0;
            if (en && !frontEn)
                for (int p = 0; p < P; p++)
                    for (int i = 0; i < W; i++) begin
                        if (wbValid[p] && expUop[i].tagA == wbTag[p])
                            expUop[i].availA = 1'b1;
                        if (wbValid[p] && expUop[i].tagB == wbTag[p])
                            expUop[i].availB = 1'b1;
                    end
        end
        renamedLast = doRename;

        for (int p = 0; p < P; p++)
            if (wbValid[p])
                readySet[wbTag[p]] = 1'b1;
        for (int i = 0; i < W; i++)
            if (issue[i]) begin
                specMap[inRd[i]] = newTag[i];
                readySet[newTag[i]] = 1'b0;
                freeSet[newTag[i]] = 1'b0;
                specSet[newTag[i]] = 1'b1;
            end
        comOld = comMap;
        for (int i = 0; i < nCom; i++) begin
            newest = !(i + 1 < nCom && comNmDst[i + 1] == comNmDst[i]);
            freeTag = newest ? comOld[comNmDst[i]] : comTagDst[i];
            readySet[comTagDst[i]] = 1'b1;
            specSet[comTagDst[i]] = 1'b0;
            comMap[comNmDst[i]] = comTagDst[i];
            freeSet[freeTag] = 1'b1;
            specSet[freeTag] = 1'b0;
        end
        for (int i = 0; i < nCom; i++) begin
            void'(robRd.pop_front());
            void'(robTag.pop_front());
        end
        if (flush) begin
            freeSet = freeSet | specSet;
            specSet = '0;
            specMap = comMap;
            seqCnt = flushSqN;
            loadCnt = flushLoadSqN;
            storeCnt = flushStoreSqN;
            robRd.delete();
            robTag.delete();
        end
    endtask

    initial begin
        rngState = 85;
        errCount = 0;
        rst = 1'b1;
        en = 1'b0;
        frontEn = 1'b0;
        flush = 1'b0;
        inValid = '0;
        inRs0 = '0;
        inRs1 = '0;
        inRd = '0;
        inFu = '{FU_ALU, FU_ALU};
        inOpcode = '{OP_ADD, OP_ADD};
        comValid = '0;
        comNmDst = '0;
        comTagDst = '0;
        wbValid = '0;
        wbTag = '0;
        flushSqN = '0;
        flushLoadSqN = '0;
        flushStoreSqN = '0;
        for (int r = 0; r < NR; r++) begin
            specMap[r] = tag_t'(r);
            comMap[r] = tag_t'(r);
        end
        readySet = '1;
        freeSet = {{(NT - NR){1'b1}}, {NR{1'b0}}};
        specSet = '0;
        seqCnt = '0;
        loadCnt = '0;
        storeCnt = '0;
        expValid = '0;
        renamedLast = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int n = 0; n < STEPS; n++) begin
            checkOutputs();
            driveStep(n);
            @(posedge clk);
            #10;
        end
        checkOutputs();
        if (errCount == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1);
        end
    end

    initial begin
        for (int c = 0; c < STEPS + 100; c++)
            @(posedge clk);
        reportFailure("simulation did not finish within the cycle limit");
    end

endmodule

`default_nettype wire

//--- verification/rename_properties.sv
`default_nettype none
`include "rename_config.svh"

module renameProperties (
    input wire clk,
    input wire rst,
    input wire allocReq [`RENAME_WIDTH],
    input wire renamePkg::tag_t allocTag [`RENAME_WIDTH],
    input wire stall,
    input wire outValid [`RENAME_WIDTH]
);

    // Both lanes allocating must get distinct tags
    assert property (@(posedge clk) disable iff (rst)
        (allocReq[0] && allocReq[1]) |-> (allocTag[0] != allocTag[1]))
        else $error("both lanes received the same tag");

    assert property (@(posedge clk) rst |=> (!outValid[0] && !outValid[1]))
        else $error("outValid high in the cycle after reset");

    // Nothing is renamed while the free pool is short
    assert property (@(posedge clk) disable iff (rst)
        stall |=> (!outValid[0] && !outValid[1]))
        else $error("outValid high after a stall cycle");

endmodule

`default_nettype wire
